/* source/sd_dat_pkg.sv */
`default_nettype none

package sd_dat_pkg;

    localparam int BLOCK_BYTES = 16;                 // Data bytes per block
    localparam int CLK_DIV     = 4;                  // i_clk cycles per nibble time
    localparam int BYTE_CNT_W  = $clog2(BLOCK_BYTES);
    localparam int DIV_W       = $clog2(CLK_DIV);

    // x^16 + x^12 + x^5 + 1, feedback into bits 12 and 5 after the shift
    localparam logic [15:0] CRC_TAPS = 16'h1020;

    // One DAT bus beat, DAT3 in the top data bit
    typedef struct packed {
        logic       stb;                             // Nibble valid this cycle
        logic [3:0] dat;
    } sd_line_t;

    typedef struct packed {
        logic crc_ok;
        logic end_ok;
    } blk_status_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_CRC,
        TX_END
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_HUNT,
        RX_DATA,
        RX_CRC,
        RX_END,
        RX_STAT
    } rx_state_e;

endpackage

`default_nettype wire

/* source/sd_dat_crc16.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_dat_crc16 import sd_dat_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_clear,                     // Zero the register, wins over i_next
    input  logic        i_next,                      // Advance by one nibble
    input  logic [3:0]  i_dat,
    output logic [15:0] o_crc16
);

    logic [15:0] crc_q;
    logic [15:0] crc_d;

    // Four serial steps per nibble, DAT3 first
    always_comb begin
        logic fb;
        crc_d = crc_q;
        for (int i = 3; i >= 0; i--) begin
            fb    = crc_d[15] ^ i_dat[i];
            crc_d = {crc_d[14:0], fb} ^ (fb ? CRC_TAPS : 16'h0000);
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc_q <= '0;
        end else if (i_clear) begin
            crc_q <= '0;
        end else if (i_next) begin
            crc_q <= crc_d;
        end
    end

    assign o_crc16 = crc_q;

    // The framer never clears and steps on the same nibble
    a_clear_next_excl: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        !(i_clear && i_next)
    );

endmodule

`default_nettype wire

/* source/sd_dat_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_dat_tx import sd_dat_pkg::*; (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_tx_req,
    input  logic [7:0] i_tx_byte,
    output logic       o_tx_ack,
    output sd_line_t   o_line
);

    tx_state_e             state_q;
    logic [DIV_W-1:0]      div_q;                    // Cycles left until next strobe allowed
    logic [BYTE_CNT_W-1:0] byte_q;
    logic                  lo_nib_q;                 // Low nibble of cur_q goes next
    logic [1:0]            crc_idx_q;
    logic                  buf_full_q;
    logic                  ack_q;
    logic [7:0]            buf_q;
    logic [7:0]            cur_q;
    sd_line_t              line_q;
    logic [15:0]           crc16;

    logic       div_zero;
    logic       latch;                               // Byte accepted from host
    logic       take;                                // Buffered byte moves to cur_q
    logic       emit;
    logic [3:0] nib;
    logic       crc_clear;
    logic       crc_next;

    assign div_zero = (div_q == '0);
    assign latch    = i_tx_req && !ack_q && !buf_full_q;

    always_comb begin
        take      = 1'b0;
        emit      = 1'b0;
        nib       = 4'hF;
        crc_clear = 1'b0;
        crc_next  = 1'b0;
        case (state_q)
            TX_START: begin
                emit      = div_zero;
                nib       = 4'h0;
                crc_clear = div_zero;
            end
            TX_DATA: begin
                if (lo_nib_q) begin
                    emit = div_zero;
                    nib  = cur_q[3:0];
                end else begin
                    take = div_zero && buf_full_q;   // Stall here until a byte arrives
                    emit = take;
                    nib  = buf_q[7:4];
                end
                crc_next = emit;
            end
            TX_CRC: begin
                emit = div_zero;
                nib  = crc16[{~crc_idx_q, 2'b00} +: 4]; // MS nibble first
            end
            TX_END: begin
                emit = div_zero;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q    <= TX_IDLE;
            div_q      <= '0;
            byte_q     <= '0;
            lo_nib_q   <= 1'b0;
            crc_idx_q  <= '0;
            buf_full_q <= 1'b0;
            ack_q      <= 1'b0;
            line_q     <= '{stb: 1'b0, dat: 4'hF};
        end else begin
            ack_q <= ack_q ? i_tx_req : latch;       // Falls the cycle after req drops
            if (latch) buf_full_q <= 1'b1;
            else if (take) buf_full_q <= 1'b0;

            if (emit) div_q <= DIV_W'(CLK_DIV - 1);
            else if (!div_zero) div_q <= div_q - 1'b1;

            line_q.stb <= emit;
            if (emit) line_q.dat <= nib;

            case (state_q)
                TX_IDLE: if (buf_full_q) state_q <= TX_START;
                TX_START: if (emit) state_q <= TX_DATA;
                TX_DATA: begin
                    if (emit) begin
                        lo_nib_q <= !lo_nib_q;
                        if (lo_nib_q) begin
                            if (byte_q == BYTE_CNT_W'(BLOCK_BYTES - 1)) begin
                                byte_q  <= '0;
                                state_q <= TX_CRC;
                            end else begin
                                byte_q <= byte_q + 1'b1;
                            end
                        end
                    end
                end
                TX_CRC: begin
                    if (emit) begin
                        crc_idx_q <= crc_idx_q + 1'b1;
                        if (crc_idx_q == 2'd3) state_q <= TX_END;
                    end
                end
                TX_END: if (emit) state_q <= TX_IDLE;
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (latch) buf_q <= i_tx_byte;
        if (take) cur_q <= buf_q;
    end

    sd_dat_crc16 crc0 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (nib),
        .o_crc16 (crc16)
    );

    assign o_tx_ack = ack_q;
    assign o_line   = line_q;

    a_ack_after_req: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        $rose(o_tx_ack) |-> $past(i_tx_req)
    );

    a_stb_spacing: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_line.stb |=> !o_line.stb [*(CLK_DIV - 1)]
    );

endmodule

`default_nettype wire

/* source/sd_dat_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_dat_rx import sd_dat_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  sd_line_t    i_line,
    output logic        o_rx_valid,
    output logic [7:0]  o_rx_byte,
    output logic        o_stat_req,
    output blk_status_t o_stat,
    input  logic        i_stat_ack
);

    rx_state_e             state_q;
    logic [BYTE_CNT_W-1:0] byte_q;
    logic                  lo_nib_q;                 // Next data nibble completes a byte
    logic [1:0]            crc_idx_q;
    logic                  valid_q;
    logic                  req_q;
    logic [3:0]            hi_q;
    logic [7:0]            rx_byte_q;
    logic [15:0]           rx_crc_q;                 // CRC as sent by the far end
    blk_status_t           stat_q;
    logic [15:0]           crc16;

    logic stb;
    logic crc_clear;
    logic crc_next;

    assign stb       = i_line.stb;
    assign crc_clear = (state_q == RX_HUNT) && stb && (i_line.dat == 4'h0); // Start nibble
    assign crc_next  = (state_q == RX_DATA) && stb;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q   <= RX_HUNT;
            byte_q    <= '0;
            lo_nib_q  <= 1'b0;
            crc_idx_q <= '0;
            valid_q   <= 1'b0;
            req_q     <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                RX_HUNT: begin
                    if (crc_clear) begin
                        state_q  <= RX_DATA;
                        byte_q   <= '0;
                        lo_nib_q <= 1'b0;
                    end
                end
                RX_DATA: begin
                    if (stb) begin
                        lo_nib_q <= !lo_nib_q;
                        valid_q  <= lo_nib_q;
                        if (lo_nib_q) begin
                            byte_q <= byte_q + 1'b1;
                            if (byte_q == BYTE_CNT_W'(BLOCK_BYTES - 1)) state_q <= RX_CRC;
                        end
                    end
                end
                RX_CRC: begin
                    if (stb) begin
                        crc_idx_q <= crc_idx_q + 1'b1;
                        if (crc_idx_q == 2'd3) state_q <= RX_END;
                    end
                end
                RX_END: begin
                    if (stb) begin
                        req_q   <= 1'b1;
                        state_q <= RX_STAT;
                    end
                end
                RX_STAT: begin
                    // Line is ignored until the status handshake finishes
                    if (req_q && i_stat_ack) req_q <= 1'b0;
                    if (!req_q && !i_stat_ack) state_q <= RX_HUNT;
                end
                default: state_q <= RX_HUNT;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (crc_next && !lo_nib_q) hi_q <= i_line.dat;
        if (crc_next && lo_nib_q) rx_byte_q <= {hi_q, i_line.dat};
        if ((state_q == RX_CRC) && stb) rx_crc_q <= {rx_crc_q[11:0], i_line.dat};
        if ((state_q == RX_END) && stb) begin
            stat_q.crc_ok <= (rx_crc_q == crc16);
            stat_q.end_ok <= (i_line.dat == 4'hF);
        end
    end

    sd_dat_crc16 crc0 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (i_line.dat),
        .o_crc16 (crc16)
    );

    assign o_rx_valid = valid_q;
    assign o_rx_byte  = rx_byte_q;
    assign o_stat_req = req_q;
    assign o_stat     = stat_q;

    a_stat_stable: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_stat_req |=> !o_stat_req || $stable(o_stat)
    );

endmodule

`default_nettype wire

/* source/sd_dat_link.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_dat_link import sd_dat_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_tx_req,
    input  logic [7:0]  i_tx_byte,
    output logic        o_tx_ack,
    output sd_line_t    o_line,                      // DAT lines towards the card
    input  sd_line_t    i_line,                      // DAT lines from the card
    output logic        o_rx_valid,
    output logic [7:0]  o_rx_byte,
    output logic        o_stat_req,
    output blk_status_t o_stat,
    input  logic        i_stat_ack
);

    // Host to card
    sd_dat_tx tx0 (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_tx_req  (i_tx_req),
        .i_tx_byte (i_tx_byte),
        .o_tx_ack  (o_tx_ack),
        .o_line    (o_line)
    );

    // Card to host
    sd_dat_rx rx0 (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_line     (i_line),
        .o_rx_valid (o_rx_valid),
        .o_rx_byte  (o_rx_byte),
        .o_stat_req (o_stat_req),
        .o_stat     (o_stat),
        .i_stat_ack (i_stat_ack)
    );

endmodule

`default_nettype wire

/* tests/sd_dat_model.svh */
`ifndef SD_DAT_MODEL_SVH
`define SD_DAT_MODEL_SVH

// Bit-serial CRC16 with generator x^16 + x^12 + x^5 + 1, DAT3 enters first
function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [3:0] nib);
    logic [15:0] c;
    logic        msb;
    c = crc;
    for (int b = 3; b >= 0; b--) begin
        msb = c[15] ^ nib[b];
        c   = c << 1;
        if (msb) c = c ^ 16'h1021;                   // Low terms of the generator
    end
    return c;
endfunction

// Start nibble, data high nibble first, CRC MS nibble first, end nibble
function automatic void build_frame(input logic [7:0] data [BLOCK_BYTES],
                                    output logic [3:0] nibs [FRAME_NIBS]);
    logic [15:0] crc;
    crc     = '0;
    nibs[0] = 4'h0;
    for (int i = 0; i < BLOCK_BYTES; i++) begin
        nibs[2 * i + 1] = data[i][7:4];
        nibs[2 * i + 2] = data[i][3:0];
    end
    for (int n = 1; n <= 2 * BLOCK_BYTES; n++) crc = crc16_step(crc, nibs[n]);
    for (int k = 0; k < 4; k++) nibs[2 * BLOCK_BYTES + 1 + k] = crc[15 - 4 * k -: 4];
    nibs[FRAME_NIBS - 1] = 4'hF;
endfunction

// Byte as the receiver should see it once the injector has hit nibble idx
function automatic logic [7:0] expected_byte(input logic [7:0] b, input int pos,
                                             input int idx, input logic [3:0] mask);
    logic [7:0] r;
    r = b;
    if (idx >= 1 && idx <= 2 * BLOCK_BYTES && (idx - 1) / 2 == pos) begin
        if ((idx - 1) % 2 == 0) r[7:4] = r[7:4] ^ mask;
        else r[3:0] = r[3:0] ^ mask;
    end
    return r;
endfunction

`endif

/* tests/sd_dat_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_dat_link_tb import sd_dat_pkg::*; ();

    localparam int          CLK_PERIOD  = 20;
    localparam int          NUM_BLOCKS  = 20;
    localparam int          FRAME_NIBS  = 2 * BLOCK_BYTES + 6;
    localparam int          WATCHDOG_NS = 2 * NUM_BLOCKS * FRAME_NIBS * (CLK_DIV + 20) * CLK_PERIOD;
    localparam logic [31:0] SEED        = 32'h9acc_160e;

    logic        clk;
    logic        nrst;
    logic        tx_req;
    logic [7:0]  tx_byte;
    logic        tx_ack;
    sd_line_t    line_out;
    sd_line_t    line_in;
    logic        rx_valid;
    logic [7:0]  rx_byte;
    logic        stat_req;
    blk_status_t stat;
    logic        stat_ack;

    int         fault_idx  = -1;                     // Frame nibble to corrupt or -1
    logic [3:0] fault_mask = 4'h0;
    logic [3:0] flip;
    int         tx_nib_idx = 0;
    int         since_stb  = CLK_DIV;
    int         value_errs = 0;
    int         proto_errs = 0;
    logic       prev_tx_req   = 1'b0;
    logic       prev_tx_ack   = 1'b0;
    logic       prev_stat_req = 1'b0;
    logic       prev_stat_ack = 1'b0;
    sd_line_t   exp_line_q [$];
    logic [7:0] exp_rx_q [$];

    `include "sd_dat_model.svh"

    sd_dat_link dut0 (
        .i_clk      (clk),
        .i_nrst     (nrst),
        .i_tx_req   (tx_req),
        .i_tx_byte  (tx_byte),
        .o_tx_ack   (tx_ack),
        .o_line     (line_out),
        .i_line     (line_in),
        .o_rx_valid (rx_valid),
        .o_rx_byte  (rx_byte),
        .o_stat_req (stat_req),
        .o_stat     (stat),
        .i_stat_ack (stat_ack)
    );

    // Loopback with a one-nibble fault
    assign flip    = (line_out.stb && tx_nib_idx == fault_idx) ? fault_mask : 4'h0;
    assign line_in = '{stb: line_out.stb, dat: line_out.dat ^ flip};

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout at %0t: a frame or handshake never completed", $time);
        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        $display("Simulation failed");
        $finish;
    end

    task automatic report_error(input string msg);
        proto_errs++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input sd_line_t got, input sd_line_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail %0t %s: got stb %b dat %h, expected stb %b dat %h",
                     $time, name, got.stb, got.dat, exp.stb, exp.dat);
        end
    endtask

    task automatic check_status(input string name, input blk_status_t got,
                                input blk_status_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail %0t %s: got crc_ok %b end_ok %b, expected crc_ok %b end_ok %b",
                     $time, name, got.crc_ok, got.end_ok, exp.crc_ok, exp.end_ok);
        end
    endtask

    task automatic check_reset_outputs();
        check_line("o_line", line_out, '{stb: 1'b0, dat: 4'hF});
        check_bit("o_tx_ack", tx_ack, 1'b0);
        check_bit("o_rx_valid", rx_valid, 1'b0);
        check_bit("o_stat_req", stat_req, 1'b0);
    endtask

    // Line, byte and handshake checks on every edge
    always @(posedge clk) begin : monitor_outputs
        sd_line_t exp_nib;
        if (nrst) begin
            if (line_out.stb) begin
                if (exp_line_q.size() == 0) begin
                    report_error("strobe on o_line while no frame was expected");
                end else begin
                    exp_nib = exp_line_q.pop_front();
                    check_line("o_line", line_out, exp_nib);
                end
                if (since_stb < CLK_DIV) report_error("strobes on o_line too close together");
                since_stb  <= 1;
                tx_nib_idx <= (tx_nib_idx == FRAME_NIBS - 1) ? 0 : tx_nib_idx + 1;
            end else begin
                since_stb <= since_stb + 1;
            end
            if (rx_valid) begin
                if (exp_rx_q.size() == 0) report_error("o_rx_valid with no byte expected");
                else check_byte("o_rx_byte", rx_byte, exp_rx_q.pop_front());
            end
            if (!prev_tx_ack && tx_ack && !prev_tx_req) report_error("o_tx_ack rose without request");
            if (prev_tx_ack && tx_ack != prev_tx_req) report_error("o_tx_ack did not follow request");
            if (prev_stat_req && !stat_req && !prev_stat_ack) begin
                report_error("o_stat_req dropped before i_stat_ack");
            end
        end
        prev_tx_req   <= tx_req;
        prev_tx_ack   <= tx_ack;
        prev_stat_req <= stat_req;
        prev_stat_ack <= stat_ack;
    end

    task automatic send_bytes(input logic [7:0] data [BLOCK_BYTES]);
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            repeat ($urandom % 21) @(posedge clk);
            tx_req  <= 1'b1;
            tx_byte <= data[i];
            do @(posedge clk); while (!tx_ack);
            tx_req <= 1'b0;
            do @(posedge clk); while (tx_ack);
        end
    endtask

    task automatic ack_status(input blk_status_t exp);
        do @(posedge clk); while (!stat_req);
        check_status("o_stat", stat, exp);
        repeat ($urandom % 11) @(posedge clk);
        stat_ack <= 1'b1;
        do @(posedge clk); while (stat_req);
        stat_ack <= 1'b0;
        @(posedge clk);                              // Receiver goes back to hunting
    endtask

    task automatic run_block(input int blk);
        logic [7:0]  data [BLOCK_BYTES];
        logic [3:0]  nibs [FRAME_NIBS];
        int          kind;
        blk_status_t exp_stat;
        for (int i = 0; i < BLOCK_BYTES; i++) data[i] = 8'($urandom);
        build_frame(data, nibs);
        kind       = $urandom % 4;
        fault_idx  = -1;
        fault_mask = 4'h0;
        exp_stat   = '{crc_ok: 1'b1, end_ok: 1'b1};
        if (kind == 0) begin                         // Flip a data nibble
            fault_idx       = 1 + $urandom % (2 * BLOCK_BYTES);
            fault_mask      = 4'(1 + $urandom % 15);
            exp_stat.crc_ok = 1'b0;
        end else if (kind == 1) begin                // Corrupt the end nibble
            fault_idx       = FRAME_NIBS - 1;
            fault_mask      = 4'(1 + $urandom % 15);
            exp_stat.end_ok = 1'b0;
        end
        for (int n = 0; n < FRAME_NIBS; n++) exp_line_q.push_back('{stb: 1'b1, dat: nibs[n]});
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            exp_rx_q.push_back(expected_byte(data[i], i, fault_idx, fault_mask));
        end
        fork
            send_bytes(data);
            ack_status(exp_stat);
        join
        if (exp_line_q.size() != 0) begin
            report_error($sformatf("block %0d left %0d nibbles unsent", blk, exp_line_q.size()));
            exp_line_q.delete();
        end
        if (exp_rx_q.size() != 0) begin
            report_error($sformatf("block %0d left %0d bytes unreceived", blk, exp_rx_q.size()));
            exp_rx_q.delete();
        end
    endtask

    initial begin
        void'($urandom(SEED));
        nrst     = 1'b0;
        tx_req   = 1'b0;
        tx_byte  = 8'h00;
        stat_ack = 1'b0;
        @(posedge clk);                              // Flops are in reset from here on
        repeat (9) begin
            @(posedge clk);
            check_reset_outputs();
        end
        nrst <= 1'b1;
        @(posedge clk);
        check_reset_outputs();
        for (int blk = 0; blk < NUM_BLOCKS; blk++) run_block(blk);
        repeat (10) @(posedge clk);
        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sd_dat_link.f */
+incdir+tests
source/sd_dat_pkg.sv
source/sd_dat_crc16.sv
source/sd_dat_tx.sv
source/sd_dat_rx.sv
source/sd_dat_link.sv
tests/sd_dat_link_tb.sv
